// File: verilog/barrel_cfg.svh
//**********************************************************
// Build-time constants of the barrel subsystem.
// Include wherever a slot count, width or timing value is needed.
//**********************************************************
`ifndef BARREL_CFG_SVH
`define BARREL_CFG_SVH

// Number of barrel slots, 1 to 8.
`define BARREL_COUNT 5

// Horizontal position width and the exit position.
`define BARREL_X_W 10
`define BARREL_X_MAX 40

// Clock cycles per one-pixel move.
`define BARREL_STEP_CYCLES 2

// Cycles of key lockout after a spawn.
`define BARREL_COOLDOWN 16

`define BARREL_AXI_AW 6

`endif

// File: verilog/barrel_pkg.sv
//**********************************************************
// Shared types, FSM states and register map of the barrel subsystem.
//**********************************************************
`include "barrel_cfg.svh"

package barrel_pkg;

    typedef logic [`BARREL_COUNT-1:0] slot_mask_t;   // One bit per slot.
    typedef logic [`BARREL_X_W-1:0] xpos_t;
    typedef logic [`BARREL_AXI_AW-1:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [1:0] axi_resp_t;

    typedef enum logic [0:0] {
        ST_IDLE     = 1'b0,
        ST_COOLDOWN = 1'b1
    } ctl_state_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Byte offsets.
    localparam axi_addr_t REG_CTRL     = 'h00;
    localparam axi_addr_t REG_KEY      = 'h04;
    localparam axi_addr_t REG_STATUS   = 'h08;
    localparam axi_addr_t REG_POS_BASE = 'h10;   // Slot i at +4*i.

endpackage

// File: verilog/barrel_mover.sv
//**********************************************************
// Horizontal mover for one barrel slot.
// Steps the position while active and flags the exit at the right edge.
//**********************************************************
`timescale 1ns/10ps
`include "barrel_cfg.svh"

module barrel_mover (
    input  logic              clk,
    input  logic              rst,
    input  logic              active,
    output barrel_pkg::xpos_t xpos,
    output logic              done
);

    localparam int STEP_W = $clog2(`BARREL_STEP_CYCLES + 1);
    localparam logic [STEP_W-1:0] STEP_LAST = STEP_W'(`BARREL_STEP_CYCLES - 1);
    localparam barrel_pkg::xpos_t X_MAX = barrel_pkg::xpos_t'(`BARREL_X_MAX);

    logic [STEP_W-1:0] step_cnt, step_cnt_nxt;
    barrel_pkg::xpos_t xpos_nxt;
    logic at_max;

    assign at_max = (xpos == X_MAX);
    assign done   = active && at_max;   // Level, held until active drops.

    always_ff @(posedge clk) begin : pos_seq_blk
        if (rst) begin
            xpos     <= '0;
            step_cnt <= '0;
        end else begin
            xpos     <= xpos_nxt;
            step_cnt <= step_cnt_nxt;
        end
    end

    always_comb begin : pos_comb_blk
        xpos_nxt     = xpos;
        step_cnt_nxt = step_cnt;
        if (!active) begin
            // An idle slot parks at the left edge so the next spawn starts from 0.
            xpos_nxt     = '0;
            step_cnt_nxt = '0;
        end else if (!at_max) begin
            if (step_cnt == STEP_LAST) begin
                step_cnt_nxt = '0;
                xpos_nxt     = xpos + 1'b1;
            end else begin
                step_cnt_nxt = step_cnt + 1'b1;
            end
        end
    end

endmodule

// File: verilog/barrel_ctl.sv
//**********************************************************
// Barrel slot allocator with spawn cooldown.
// Spawns on key into the lowest free slot and frees a slot when its mover is done.
//**********************************************************
`timescale 1ns/10ps
`include "barrel_cfg.svh"

module barrel_ctl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_game,
    input  logic                   animation,
    input  logic                   key,
    input  barrel_pkg::slot_mask_t done,
    output barrel_pkg::slot_mask_t barrel,
    output logic                   busy
);

    localparam int COOL_W = $clog2(`BARREL_COOLDOWN + 1);
    localparam logic [COOL_W-1:0] COOL_LOAD = COOL_W'(`BARREL_COOLDOWN - 1);

    barrel_pkg::ctl_state_t state, state_nxt;

    logic [COOL_W-1:0] cool_cnt, cool_cnt_nxt;

    barrel_pkg::slot_mask_t barrel_nxt;
    barrel_pkg::slot_mask_t done_q;
    barrel_pkg::slot_mask_t done_rise;
    barrel_pkg::slot_mask_t free_pick;

    logic spawn;

    // Lowest zero bit of the mask, all zero when every slot is taken.
    assign free_pick = ~barrel & (barrel + 1'b1);

    assign done_rise = done & ~done_q;

    assign spawn = (state == barrel_pkg::ST_IDLE) && key && start_game && !animation
                   && (free_pick != '0);

    assign busy = (state == barrel_pkg::ST_COOLDOWN);

    always_ff @(posedge clk) begin : state_seq_blk
        if (rst) begin
            state    <= barrel_pkg::ST_IDLE;
            cool_cnt <= '0;
        end else begin
            state    <= state_nxt;
            cool_cnt <= cool_cnt_nxt;
        end
    end

    always_ff @(posedge clk) begin : mask_seq_blk
        if (rst) begin
            barrel <= '0;
            done_q <= '0;
        end else begin
            barrel <= barrel_nxt;
            done_q <= done;
        end
    end

    always_comb begin : state_comb_blk
        state_nxt    = state;
        cool_cnt_nxt = cool_cnt;
        case (state)
            barrel_pkg::ST_IDLE: begin
                if (spawn) begin
                    state_nxt    = barrel_pkg::ST_COOLDOWN;
                    cool_cnt_nxt = COOL_LOAD;
                end
            end

            barrel_pkg::ST_COOLDOWN: begin
                if (cool_cnt == '0) begin
                    state_nxt = barrel_pkg::ST_IDLE;
                end else begin
                    cool_cnt_nxt = cool_cnt - 1'b1;
                end
            end

            default: begin
                state_nxt    = barrel_pkg::ST_IDLE;
                cool_cnt_nxt = '0;
            end
        endcase
    end

    always_comb begin : mask_comb_blk
        // Release works in both states.
        barrel_nxt = barrel & ~done_rise;
        if (spawn) begin
            barrel_nxt = barrel_nxt | free_pick;
        end
    end

endmodule

// File: verilog/barrel_axil_regs.sv
//**********************************************************
// AXI4-Lite register block of the barrel subsystem.
// Holds CTRL, makes the key pulse and returns status and positions.
//**********************************************************
`timescale 1ns/10ps
`include "barrel_cfg.svh"

module barrel_axil_regs (
    input  logic                                     clk,
    input  logic                                     rst,
    // Write address and data.
    input  barrel_pkg::axi_addr_t                    awaddr,
    input  logic                                     awvalid,
    output logic                                     awready,
    input  barrel_pkg::axi_data_t                    wdata,
    input  logic [3:0]                               wstrb,
    input  logic                                     wvalid,
    output logic                                     wready,
    // Write response.
    output barrel_pkg::axi_resp_t                    bresp,
    output logic                                     bvalid,
    input  logic                                     bready,
    // Read address and data.
    input  barrel_pkg::axi_addr_t                    araddr,
    input  logic                                     arvalid,
    output logic                                     arready,
    output barrel_pkg::axi_data_t                    rdata,
    output barrel_pkg::axi_resp_t                    rresp,
    output logic                                     rvalid,
    input  logic                                     rready,
    // Game side.
    input  barrel_pkg::slot_mask_t                   barrel,
    input  logic                                     busy,
    input  logic [`BARREL_COUNT*`BARREL_X_W-1:0]     xpos_all,
    output logic                                     start_game,
    output logic                                     animation,
    output logic                                     key
);

    logic wr_hs;
    logic rd_hs;
    logic wr_ctrl;
    logic wr_key;
    logic rd_ok;
    barrel_pkg::axi_data_t rd_data_nxt;

    assign wr_hs  = awvalid && awready;   // wvalid is high whenever awready is.
    assign rd_hs  = arvalid && arready;
    assign wready = awready;

    always_comb begin : wr_dec_blk
        barrel_pkg::axi_addr_t off;
        off     = {awaddr[`BARREL_AXI_AW-1:2], 2'b00};
        wr_ctrl = 1'b0;
        wr_key  = 1'b0;
        case (off)
            barrel_pkg::REG_CTRL: wr_ctrl = 1'b1;
            barrel_pkg::REG_KEY:  wr_key  = 1'b1;
            default: ;   // Read-only and unmapped offsets.
        endcase
    end

    always_comb begin : rd_dec_blk
        barrel_pkg::axi_addr_t off;
        off         = {araddr[`BARREL_AXI_AW-1:2], 2'b00};
        rd_data_nxt = '0;
        rd_ok       = 1'b1;
        case (off)
            barrel_pkg::REG_CTRL: begin
                rd_data_nxt[1:0] = {animation, start_game};
            end

            barrel_pkg::REG_KEY: ;   // Write only, reads as 0.

            barrel_pkg::REG_STATUS: begin
                rd_data_nxt[`BARREL_COUNT-1:0] = barrel;
                rd_data_nxt[8]                 = busy;
            end

            default: begin
                rd_ok = 1'b0;
                for (int i = 0; i < `BARREL_COUNT; i++) begin
                    if (off == barrel_pkg::axi_addr_t'(barrel_pkg::REG_POS_BASE + 4 * i)) begin
                        rd_data_nxt[`BARREL_X_W-1:0] = xpos_all[i*`BARREL_X_W +: `BARREL_X_W];
                        rd_ok = 1'b1;
                    end
                end
            end
        endcase
    end

    // Write channel.
    always_ff @(posedge clk) begin : wr_ch_blk
        if (rst) begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin : bresp_blk
        if (wr_hs) begin
            bresp <= (wr_ctrl || wr_key) ? barrel_pkg::RESP_OKAY : barrel_pkg::RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin : ctrl_reg_blk
        if (rst) begin
            start_game <= 1'b0;
            animation  <= 1'b0;
            key        <= 1'b0;
        end else begin
            if (wr_hs && wr_ctrl && wstrb[0]) begin
                {animation, start_game} <= wdata[1:0];
            end
            key <= wr_hs && wr_key && wstrb[0] && wdata[0];   // One cycle only.
        end
    end

    // Read channel.
    always_ff @(posedge clk) begin : rd_ch_blk
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Loaded only on a read handshake, so data holds under back-pressure.
    always_ff @(posedge clk) begin : rdata_blk
        if (rd_hs) begin
            rdata <= rd_data_nxt;
            rresp <= rd_ok ? barrel_pkg::RESP_OKAY : barrel_pkg::RESP_SLVERR;
        end
    end

endmodule

// File: verilog/barrel_field.sv
//**********************************************************
// Barrel subsystem top. Connect the AXI4-Lite ports to the game CPU.
//**********************************************************
`timescale 1ns/10ps
`include "barrel_cfg.svh"

module barrel_field (
    input  logic                  clk,
    input  logic                  rst,
    input  barrel_pkg::axi_addr_t awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  barrel_pkg::axi_data_t wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output barrel_pkg::axi_resp_t bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  barrel_pkg::axi_addr_t araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output barrel_pkg::axi_data_t rdata,
    output barrel_pkg::axi_resp_t rresp,
    output logic                  rvalid,
    input  logic                  rready
);

    logic start_game;
    logic animation;
    logic key;
    logic busy;
    barrel_pkg::slot_mask_t barrel;
    barrel_pkg::slot_mask_t done;
    logic [`BARREL_COUNT*`BARREL_X_W-1:0] xpos_all;   // Slot i at bits i*W.

    barrel_axil_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .barrel     (barrel),
        .busy       (busy),
        .xpos_all   (xpos_all),
        .start_game (start_game),
        .animation  (animation),
        .key        (key)
    );

    barrel_ctl u_ctl (
        .clk        (clk),
        .rst        (rst),
        .start_game (start_game),
        .animation  (animation),
        .key        (key),
        .done       (done),
        .barrel     (barrel),
        .busy       (busy)
    );

    for (genvar i = 0; i < `BARREL_COUNT; i++) begin : g_mover
        barrel_mover u_mover (
            .clk    (clk),
            .rst    (rst),
            .active (barrel[i]),
            .xpos   (xpos_all[i*`BARREL_X_W +: `BARREL_X_W]),
            .done   (done[i])
        );
    end

endmodule

// File: tests/barrel_field_checker.sv
//**********************************************************
// Bus handshake and slot rule assertions.
// Bound into the barrel subsystem top.
//**********************************************************
`timescale 1ns/10ps
`include "barrel_cfg.svh"

module barrel_field_checker (
    input logic                   clk,
    input logic                   rst,
    input logic                   key,
    input logic                   busy,
    input barrel_pkg::slot_mask_t barrel,
    input barrel_pkg::slot_mask_t done,
    input logic                   bvalid,
    input logic                   bready,
    input logic                   rvalid,
    input logic                   rready,
    input barrel_pkg::axi_data_t  rdata,
    input barrel_pkg::axi_resp_t  rresp
);

    int fail_count = 0;   // Watched by the testbench.

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped before bready");
        end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            fail_count++;
            $error("Read response changed before rready");
        end

    for (genvar i = 0; i < `BARREL_COUNT; i++) begin : g_slot
        // A slot fills only from a key seen outside cooldown.
        a_spawn: assert property (@(posedge clk) disable iff (rst)
            $rose(barrel[i]) |-> $past(key) && !$past(busy))
            else begin
                fail_count++;
                $error("Slot %0d set without a legal key", i);
            end

        a_release: assert property (@(posedge clk) disable iff (rst)
            $rose(done[i]) |=> !barrel[i])
            else begin
                fail_count++;
                $error("Slot %0d not freed after done", i);
            end
    end

endmodule

bind barrel_field barrel_field_checker u_checker (
    .clk    (clk),
    .rst    (rst),
    .key    (key),
    .busy   (busy),
    .barrel (barrel),
    .done   (done),
    .bvalid (bvalid),
    .bready (bready),
    .rvalid (rvalid),
    .rready (rready),
    .rdata  (rdata),
    .rresp  (rresp)
);

// File: tests/barrel_field_tb.sv
//**********************************************************
// Testbench for the barrel subsystem.
// Drives the AXI4-Lite port as the game CPU.
//**********************************************************
`timescale 1ns/10ps
`include "barrel_cfg.svh"

module barrel_field_tb;

    localparam int TIMEOUT_CYCLES = 4000;   // About ten times the expected run.
    localparam int LEAVE_BOUND = 2 * `BARREL_X_MAX * `BARREL_STEP_CYCLES + 40;
    localparam int KEY_GAP = `BARREL_COOLDOWN - 2;   // Next key lands two cycles after cooldown.
    localparam barrel_pkg::axi_resp_t OKAY = barrel_pkg::RESP_OKAY;
    localparam barrel_pkg::axi_resp_t SLVERR = barrel_pkg::RESP_SLVERR;

    logic clk, rst;
    barrel_pkg::axi_addr_t awaddr, araddr;
    barrel_pkg::axi_data_t wdata, rdata;
    barrel_pkg::axi_resp_t bresp, rresp;
    logic [3:0] wstrb;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;

    int cycle = 0;
    int max_delay;   // Upper bound of the bready/rready delay.
    barrel_pkg::slot_mask_t exp_mask;

    barrel_field u_barrel_field (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin : watchdog_blk
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the test sequence did not finish.", cycle);
            $display("sim failed");
            $fatal(1);
        end
    end

    always @(negedge clk) begin : assert_watch_blk
        if (u_barrel_field.u_checker.fail_count != 0) begin
            $display("A bound assertion failed at %0t ns.", $time);
            $display("sim failed");
            $fatal(1);
        end
    end

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic axi_write(input barrel_pkg::axi_addr_t addr, input logic [31:0] data,
                             output barrel_pkg::axi_resp_t resp);
        int delay;
        delay = $urandom_range(max_delay);
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hf;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!awready) begin
            @(negedge clk);
        end
        check_eq("wready", 32'h1, wready);   // Raised together with awready.
        @(posedge clk);   // Address and data handshake.
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        repeat (delay) @(posedge clk);
        bready <= 1'b1;
        @(negedge clk);
        while (!bvalid) begin
            @(negedge clk);
        end
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input barrel_pkg::axi_addr_t addr, output logic [31:0] data,
                            output barrel_pkg::axi_resp_t resp);
        int delay;
        delay = $urandom_range(max_delay);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) begin
            @(negedge clk);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        repeat (delay) @(posedge clk);
        rready <= 1'b1;
        @(negedge clk);
        while (!rvalid) begin
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic write_reg(input barrel_pkg::axi_addr_t addr, input logic [31:0] data,
                             input barrel_pkg::axi_resp_t exp_resp);
        barrel_pkg::axi_resp_t resp;
        axi_write(addr, data, resp);
        check_eq($sformatf("bresp@0x%02h", addr), exp_resp, resp);
    endtask

    // Data is only compared on an OKAY response.
    task automatic read_reg(input barrel_pkg::axi_addr_t addr, input logic [31:0] exp_data,
                            input barrel_pkg::axi_resp_t exp_resp);
        barrel_pkg::axi_resp_t resp;
        logic [31:0] data;
        axi_read(addr, data, resp);
        check_eq($sformatf("rresp@0x%02h", addr), exp_resp, resp);
        if (exp_resp == OKAY) begin
            check_eq($sformatf("rdata@0x%02h", addr), exp_data, data);
        end
    endtask

    task automatic press_key();
        write_reg(barrel_pkg::REG_KEY, 32'h1, OKAY);
    endtask

    task automatic wait_until(input int target);
        while (cycle < target) begin
            @(posedge clk);
        end
    endtask

    function automatic logic [31:0] status_word(input barrel_pkg::slot_mask_t mask,
                                                input logic busy_bit);
        logic [31:0] w;
        w = '0;
        w[`BARREL_COUNT-1:0] = mask;
        w[8] = busy_bit;
        return w;
    endfunction

    function automatic barrel_pkg::axi_addr_t pos_addr(input int slot);
        return barrel_pkg::axi_addr_t'(barrel_pkg::REG_POS_BASE + 4 * slot);
    endfunction

    initial begin : stimulus_blk
        barrel_pkg::axi_resp_t resp;
        logic [31:0] ctrl_val;
        logic [31:0] pos;
        logic [31:0] status;
        int mark;
        int prev_pos;
        void'($urandom(46));
        clk = 1'b0;
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        max_delay = 3;
        exp_mask = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        read_reg(barrel_pkg::REG_CTRL, 32'h0, OKAY);
        read_reg(barrel_pkg::REG_STATUS, status_word('0, 1'b0), OKAY);
        for (int i = 0; i < `BARREL_COUNT; i++) begin
            read_reg(pos_addr(i), 32'h0, OKAY);
        end

        repeat (4) begin
            ctrl_val = $urandom_range(3);
            write_reg(barrel_pkg::REG_CTRL, ctrl_val, OKAY);
            read_reg(barrel_pkg::REG_CTRL, ctrl_val, OKAY);
        end
        read_reg(barrel_pkg::REG_KEY, 32'h0, OKAY);

        // Game running, so a stray key pulse from a bad write would show in STATUS.
        write_reg(barrel_pkg::REG_CTRL, 32'h1, OKAY);
        write_reg('h0C, 32'hffff_ffff, SLVERR);
        write_reg(barrel_pkg::REG_STATUS, 32'hffff_ffff, SLVERR);
        write_reg(pos_addr(0), 32'hffff_ffff, SLVERR);
        read_reg('h0C, 32'h0, SLVERR);
        read_reg('h3C, 32'h0, SLVERR);
        read_reg(barrel_pkg::REG_CTRL, 32'h1, OKAY);
        read_reg(barrel_pkg::REG_STATUS, status_word('0, 1'b0), OKAY);

        write_reg(barrel_pkg::REG_CTRL, 32'h0, OKAY);   // Game stopped.
        press_key();
        read_reg(barrel_pkg::REG_STATUS, status_word('0, 1'b0), OKAY);
        write_reg(barrel_pkg::REG_CTRL, 32'h3, OKAY);   // Animation playing.
        press_key();
        read_reg(barrel_pkg::REG_STATUS, status_word('0, 1'b0), OKAY);

        // Fill every slot before the first barrel reaches the edge.
        write_reg(barrel_pkg::REG_CTRL, 32'h1, OKAY);
        max_delay = 0;
        for (int i = 0; i < `BARREL_COUNT; i++) begin
            press_key();
            mark = cycle;
            exp_mask[i] = 1'b1;
            if (i == 0) begin
                press_key();   // Falls inside the cooldown.
            end
            read_reg(barrel_pkg::REG_STATUS, status_word(exp_mask, 1'b1), OKAY);
            wait_until(mark + KEY_GAP);
        end

        // Follow the last barrel until it leaves.
        max_delay = 3;
        prev_pos = 0;
        status = status_word(exp_mask, 1'b0);
        while (status[`BARREL_COUNT-1] && (cycle - mark <= LEAVE_BOUND)) begin
            axi_read(pos_addr(`BARREL_COUNT - 1), pos, resp);
            check_eq("rresp pos", OKAY, resp);
            axi_read(barrel_pkg::REG_STATUS, status, resp);
            check_eq("rresp status", OKAY, resp);
            if (status[`BARREL_COUNT-1]) begin
                assert (pos >= prev_pos && pos <= `BARREL_X_MAX) else begin
                    $display("Slot %0d position went from %0d to %0d at %0t ns",
                             `BARREL_COUNT - 1, prev_pos, pos, $time);
                    $display("sim failed");
                    $fatal(1);
                end
                prev_pos = pos;
            end
        end
        exp_mask = '0;
        check_eq("STATUS after travel", status_word(exp_mask, 1'b0), status);

        press_key();
        exp_mask[0] = 1'b1;
        read_reg(barrel_pkg::REG_STATUS, status_word(exp_mask, 1'b1), OKAY);

        if (u_barrel_field.u_checker.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1);
        end
    end

endmodule

// File: barrels.f
+incdir+verilog
verilog/barrel_pkg.sv
verilog/barrel_mover.sv
verilog/barrel_ctl.sv
verilog/barrel_axil_regs.sv
verilog/barrel_field.sv
tests/barrel_field_checker.sv
tests/barrel_field_tb.sv

// File: Bender.yml
package:
  name: barrels

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/barrel_pkg.sv
      - verilog/barrel_mover.sv
      - verilog/barrel_ctl.sv
      - verilog/barrel_axil_regs.sv
      - verilog/barrel_field.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/barrel_field_checker.sv
      - tests/barrel_field_tb.sv
